// ==== pspin_sched.f ====
logic/pspin_sched_pkg.sv
logic/her_intake.sv
logic/task_fifo.sv
logic/cluster_dispatch.sv
logic/pspin_sched.sv
tests/tb_clock.sv
tests/tb_pspin_sched.sv

// ==== Makefile ====
# Verilator flow for the scheduler testbench
VERILATOR ?= verilator
FILELIST  ?= pspin_sched.f
TOP       ?= tb_pspin_sched
RTL_TOP   ?= pspin_sched
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j 0 -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Test passed" $(LOG) || (echo "No pass line in log"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_pspin_sched.sv ====
// Directed tests for the scheduler; the testbench plays the NIC and the clusters
// Inputs change on the falling edge, outputs are sampled 10 ns later or there
// Default parameters only: 4 clusters, 2 credits each, 8 MPQs of depth 4
`default_nettype none

module tb_pspin_sched import pspin_sched_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ns;

  localparam int unsigned NC      = DEF_NUM_CLUSTERS;
  localparam int unsigned NM      = DEF_NUM_MPQ;
  localparam int unsigned TIMEOUT = 200;

  logic clk, rst_n;
  logic her_valid, her_ready, nic_fb_valid, nic_fb_ready, active;
  her_descr_t her, cl_task;
  feedback_descr_t nic_fb;
  logic [NM-1:0] mpq_full;
  logic [NC-1:0] cl_task_valid, cl_task_ready, cl_fb_valid, cl_fb_ready;
  feedback_descr_t [NC-1:0] cl_fb;

  int unsigned lcg_state = 32'h94f2;
  int errors = 0;
  int checks = 0;
  // Tasks handed out and not yet completed, with their clusters
  int pend_cl[$];
  her_descr_t pend_task[$];

  tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(8)) tb_clock_i (.clk_o(clk), .rst_no(rst_n));

  pspin_sched pspin_sched_i (
    .clk_i(clk), .rst_ni(rst_n),
    .her_valid_i(her_valid), .her_ready_o(her_ready), .her_i(her),
    .mpq_full_o(mpq_full),
    .nic_feedback_valid_o(nic_fb_valid), .nic_feedback_ready_i(nic_fb_ready),
    .nic_feedback_o(nic_fb),
    .cluster_task_valid_o(cl_task_valid), .cluster_task_ready_i(cl_task_ready),
    .cluster_task_o(cl_task),
    .cluster_feedback_valid_i(cl_fb_valid), .cluster_feedback_ready_o(cl_fb_ready),
    .cluster_feedback_i(cl_fb),
    .pspin_active_o(active)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic her_descr_t random_her(input int mpq);
    her_descr_t h;
    h.mpq_id       = MPQ_ID_W'(mpq);
    h.handler_addr = lcg_next();
    h.pkt_addr     = lcg_next();
    h.pkt_size     = SIZE_W'(lcg_next() >> 8);
    return h;
  endfunction

  // Completion for a task; cluster_id is junk that the DUT must replace
  function automatic feedback_descr_t completion_of(input her_descr_t t);
    feedback_descr_t f;
    f.mpq_id     = t.mpq_id;
    f.cluster_id = CL_ID_W'(lcg_next() >> 16);
    f.pkt_addr   = t.pkt_addr;
    f.pkt_size   = t.pkt_size;
    return f;
  endfunction

  task automatic compare_task(input her_descr_t got, input her_descr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s task got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_feedback(input feedback_descr_t got, input feedback_descr_t exp,
                                  input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s feedback got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("Test failed");
    $finish;
  endtask

  // NIC side: offer one HER and hold it until accepted
  task automatic send_her(input her_descr_t h);
    int n;
    n = 0;
    her = h;
    her_valid = 1'b1;
    forever begin
      #10;
      if (her_ready) break;
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_on_timeout("her_ready_o");
    end
    @(negedge clk);
    her_valid = 1'b0;
  endtask

  // Cluster side: wait for the next task handshake, clusters always ready
  task automatic receive_task(output int cl, output her_descr_t t);
    int n;
    n = 0;
    cl = -1;
    while (cl < 0) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_on_timeout("a cluster task");
      for (int i = 0; i < NC; i++) begin
        if (cl_task_valid[i]) cl = i;
      end
    end
    compare_bit($onehot(cl_task_valid), 1'b1, "one-hot task valid");
    t = cl_task;
    pend_cl.push_back(cl);
    pend_task.push_back(t);
  endtask

  // Cluster k returns a completion; ends on the falling edge after the handshake
  task automatic return_feedback(input int k, input feedback_descr_t f);
    int n;
    n = 0;
    cl_fb[k] = f;
    cl_fb_valid[k] = 1'b1;
    forever begin
      #10;
      if (cl_fb_ready[k]) break;
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_on_timeout("cluster_feedback_ready_o");
    end
    @(negedge clk);
    cl_fb_valid[k] = 1'b0;
  endtask

  task automatic expect_nic(input feedback_descr_t exp);
    int n;
    n = 0;
    while (!nic_fb_valid) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_on_timeout("nic_feedback_valid_o");
    end
    compare_feedback(nic_fb, exp, "NIC");
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (active || nic_fb_valid) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_on_timeout("the scheduler to go idle");
    end
  endtask

  // Complete every outstanding task in hand-out order
  task automatic drain_pending();
    while (pend_cl.size() > 0) begin
      return_feedback(pend_cl.pop_front(), completion_of(pend_task.pop_front()));
    end
    wait_idle();
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%s: %0d errors", name, errors - err_before);
  endtask

  task automatic reset_state_test();
    int e;
    e = errors;
    @(negedge clk);
    #10;
    compare_bit(her_ready, 1'b1, "her_ready_o");
    compare_bit(|cl_task_valid, 1'b0, "cluster_task_valid_o");
    compare_bit(nic_fb_valid, 1'b0, "nic_feedback_valid_o");
    compare_bit(|mpq_full, 1'b0, "mpq_full_o");
    compare_bit(active, 1'b0, "pspin_active_o");
    report_test("reset_state", e);
  endtask

  task automatic round_robin_test();
    her_descr_t sent[8];
    her_descr_t t;
    int cl;
    int e;
    e = errors;
    for (int i = 0; i < 8; i++) sent[i] = random_her(i);
    fork
      for (int i = 0; i < 8; i++) send_her(sent[i]);
      for (int i = 0; i < 8; i++) begin
        receive_task(cl, t);
        compare_task(t, sent[i], "in-order");
        compare_bit(cl == (i % NC), 1'b1, "round-robin cluster");
      end
    join
    drain_pending();
    report_test("round_robin", e);
  endtask

  task automatic credit_limit_test();
    her_descr_t t, extra;
    int cl;
    int e;
    e = errors;
    fork
      for (int i = 0; i < 8; i++) send_her(random_her(i));
      for (int i = 0; i < 8; i++) receive_task(cl, t);
    join
    extra = random_her(0);
    send_her(extra);
    for (int i = 0; i < TIMEOUT; i++) begin
      @(negedge clk);
      compare_bit(|cl_task_valid, 1'b0, "task valid without credit");
    end
    compare_bit(active, 1'b1, "pspin_active_o");
    for (int i = 0; i < pend_cl.size(); i++) begin
      if (pend_cl[i] == 2) begin
        return_feedback(2, completion_of(pend_task[i]));
        pend_cl.delete(i);
        pend_task.delete(i);
        break;
      end
    end
    receive_task(cl, t);
    compare_bit(cl == 2, 1'b1, "task after credit return on cluster 2");
    compare_task(t, extra, "released");
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      compare_bit(|cl_task_valid, 1'b0, "task valid after release");
    end
    drain_pending();
    report_test("credit_limit", e);
  endtask

  task automatic mpq_limit_test();
    her_descr_t t;
    int cl;
    int n;
    int e;
    e = errors;
    fork
      for (int i = 0; i < DEF_MPQ_DEPTH; i++) send_her(random_her(1));
      for (int i = 0; i < DEF_MPQ_DEPTH; i++) receive_task(cl, t);
    join
    compare_bit(mpq_full[1], 1'b1, "mpq_full_o[1]");
    her = random_her(1);
    her_valid = 1'b1;
    for (int i = 0; i < 5; i++) begin
      #10;
      compare_bit(her_ready, 1'b0, "her_ready_o for full MPQ");
      @(negedge clk);
    end
    her_valid = 1'b0;
    send_her(random_her(2));
    receive_task(cl, t);
    return_feedback(pend_cl.pop_front(), completion_of(pend_task.pop_front()));
    n = 0;
    while (mpq_full[1] && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    compare_bit(mpq_full[1], 1'b0, "mpq_full_o[1] after feedback");
    drain_pending();
    report_test("mpq_limit", e);
  endtask

  task automatic feedback_path_test();
    her_descr_t t;
    feedback_descr_t f, exp, exp2;
    int cl;
    int cl2;
    int n;
    int e;
    e = errors;
    fork
      for (int i = 0; i < 2; i++) send_her(random_her(i + 3));
      for (int i = 0; i < 2; i++) receive_task(cl, t);
    join
    nic_fb_ready = 1'b0;
    cl = pend_cl.pop_front();
    f = completion_of(pend_task.pop_front());
    exp = f;
    exp.cluster_id = CL_ID_W'(cl);
    return_feedback(cl, f);
    expect_nic(exp);
    // Second cluster offers its completion while the NIC stalls
    cl2 = pend_cl.pop_front();
    f = completion_of(pend_task.pop_front());
    exp2 = f;
    exp2.cluster_id = CL_ID_W'(cl2);
    cl_fb[cl2] = f;
    cl_fb_valid[cl2] = 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      compare_bit(nic_fb_valid, 1'b1, "nic_feedback_valid_o held");
      compare_feedback(nic_fb, exp, "held NIC");
      compare_bit(|cl_fb_ready, 1'b0, "cluster_feedback_ready_o under back-pressure");
    end
    nic_fb_ready = 1'b1;
    return_feedback(cl2, f);
    expect_nic(exp2);
    n = 0;
    while (active && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    compare_bit(active, 1'b0, "pspin_active_o after drain");
    report_test("feedback_path", e);
  endtask

  initial begin
    int n;
    her_valid     = 1'b0;
    her           = '0;
    nic_fb_ready  = 1'b1;
    cl_task_ready = '1;
    cl_fb_valid   = '0;
    cl_fb         = '0;
    n = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) abort_on_timeout("reset release");
    end
    reset_state_test();
    round_robin_test();
    credit_limit_test();
    mpq_limit_test();
    feedback_path_test();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// Free-running clock and active-low reset for the testbench
// Reset releases on a falling edge after RESET_CYCLES rising edges
`default_nettype none

module tb_clock #(
  parameter int unsigned PERIOD_NS    = 100,
  parameter int unsigned RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ns;

  initial clk_o = 1'b0;
  always #(PERIOD_NS / 2) clk_o = ~clk_o;

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== logic/pspin_sched.sv ====
// Packet scheduling path: HER intake, task FIFO and cluster dispatch
// Clusters sit outside; each gets its own task and feedback handshake
// All clusters share one task descriptor bus
// At least two cycles pass from HER acceptance to a cluster task valid
`default_nettype none

module pspin_sched import pspin_sched_pkg::*; #(
  parameter int unsigned NUM_CLUSTERS     = DEF_NUM_CLUSTERS,
  parameter int unsigned NUM_MPQ          = DEF_NUM_MPQ,
  parameter int unsigned MPQ_DEPTH        = DEF_MPQ_DEPTH,
  parameter int unsigned HERS_PER_CLUSTER = DEF_HERS_PER_CLUSTER,
  parameter int unsigned FIFO_DEPTH       = DEF_FIFO_DEPTH
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // NIC side
  input  logic                               her_valid_i,
  output logic                               her_ready_o,
  input  her_descr_t                         her_i,
  output logic [NUM_MPQ-1:0]                 mpq_full_o,
  output logic                               nic_feedback_valid_o,
  input  logic                               nic_feedback_ready_i,
  output feedback_descr_t                    nic_feedback_o,
  // Cluster side
  output logic [NUM_CLUSTERS-1:0]            cluster_task_valid_o,
  input  logic [NUM_CLUSTERS-1:0]            cluster_task_ready_i,
  output her_descr_t                         cluster_task_o,
  input  logic [NUM_CLUSTERS-1:0]            cluster_feedback_valid_i,
  output logic [NUM_CLUSTERS-1:0]            cluster_feedback_ready_o,
  input  feedback_descr_t [NUM_CLUSTERS-1:0] cluster_feedback_i,
  output logic                               pspin_active_o
);

  // Intake to FIFO
  logic            in_task_valid;
  logic            in_task_ready;
  her_descr_t      in_task;

  // FIFO to dispatcher
  logic            out_task_valid;
  logic            out_task_ready;
  her_descr_t      out_task;

  // Dispatcher feedback toward the NIC
  logic            fb_valid;
  logic            fb_ready;
  feedback_descr_t fb;

  her_intake #(
    .NUM_MPQ              (NUM_MPQ),
    .MPQ_DEPTH            (MPQ_DEPTH)
  ) her_intake_i (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .her_valid_i          (her_valid_i),
    .her_ready_o          (her_ready_o),
    .her_i                (her_i),
    .mpq_full_o           (mpq_full_o),
    .task_valid_o         (in_task_valid),
    .task_ready_i         (in_task_ready),
    .task_o               (in_task),
    .fb_valid_i           (fb_valid),
    .fb_ready_o           (fb_ready),
    .fb_i                 (fb),
    .nic_feedback_valid_o (nic_feedback_valid_o),
    .nic_feedback_ready_i (nic_feedback_ready_i),
    .nic_feedback_o       (nic_feedback_o)
  );

  task_fifo #(
    .DEPTH       (FIFO_DEPTH),
    .payload_t   (her_descr_t)
  ) task_fifo_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_task_valid),
    .in_ready_o  (in_task_ready),
    .in_data_i   (in_task),
    .out_valid_o (out_task_valid),
    .out_ready_i (out_task_ready),
    .out_data_o  (out_task)
  );

  cluster_dispatch #(
    .NUM_CLUSTERS             (NUM_CLUSTERS),
    .HERS_PER_CLUSTER         (HERS_PER_CLUSTER)
  ) cluster_dispatch_i (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .task_valid_i             (out_task_valid),
    .task_ready_o             (out_task_ready),
    .task_i                   (out_task),
    .cluster_task_valid_o     (cluster_task_valid_o),
    .cluster_task_ready_i     (cluster_task_ready_i),
    .cluster_task_o           (cluster_task_o),
    .cluster_feedback_valid_i (cluster_feedback_valid_i),
    .cluster_feedback_ready_o (cluster_feedback_ready_o),
    .cluster_feedback_i       (cluster_feedback_i),
    .fb_valid_o               (fb_valid),
    .fb_ready_i               (fb_ready),
    .fb_o                     (fb),
    .pspin_active_o           (pspin_active_o)
  );

endmodule

`default_nettype wire

// ==== logic/cluster_dispatch.sv ====
// Task dispatch to clusters with per-cluster credits
// A cluster holds HERS_PER_CLUSTER credits; each task takes one, each feedback
// returns one
// The output slot loads only while empty, so at most one task every two cycles
// Feedback cluster_id is replaced by the port index, NUM_CLUSTERS up to 64
`default_nettype none

module cluster_dispatch import pspin_sched_pkg::*; #(
  parameter int unsigned NUM_CLUSTERS     = DEF_NUM_CLUSTERS,
  parameter int unsigned HERS_PER_CLUSTER = DEF_HERS_PER_CLUSTER
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   task_valid_i,
  output logic                                   task_ready_o,
  input  her_descr_t                             task_i,
  output logic [NUM_CLUSTERS-1:0]                cluster_task_valid_o,
  input  logic [NUM_CLUSTERS-1:0]                cluster_task_ready_i,
  output her_descr_t                             cluster_task_o,
  input  logic [NUM_CLUSTERS-1:0]                cluster_feedback_valid_i,
  output logic [NUM_CLUSTERS-1:0]                cluster_feedback_ready_o,
  input  feedback_descr_t [NUM_CLUSTERS-1:0]     cluster_feedback_i,
  output logic                                   fb_valid_o,
  input  logic                                   fb_ready_i,
  output feedback_descr_t                        fb_o,
  output logic                                   pspin_active_o
);

  localparam int unsigned IDX_W = (NUM_CLUSTERS > 1) ? $clog2(NUM_CLUSTERS) : 1;
  localparam int unsigned CR_W  = $clog2(HERS_PER_CLUSTER + 1);

  logic [NUM_CLUSTERS-1:0][CR_W-1:0] credit_q, credit_d;
  logic [NUM_CLUSTERS-1:0]           has_credit;
  logic                              slot_valid_q;
  logic [IDX_W-1:0]                  slot_cl_q;
  her_descr_t                        slot_q;
  logic [IDX_W-1:0]                  rr_task_q;
  logic                              task_found;
  logic [IDX_W-1:0]                  task_pick;
  logic                              task_load;
  logic                              slot_drain;
  logic                              fb_valid_q;
  feedback_descr_t                   fb_q;
  feedback_descr_t                   fb_tagged;
  logic [IDX_W-1:0]                  rr_fb_q;
  logic                              fb_found;
  logic [IDX_W-1:0]                  fb_pick;
  logic                              fb_free;
  logic                              fb_acc;
  logic                              active_q;
  logic                              active_d;

  // First set bit of req at or after ptr, wrapping around
  function automatic void rr_search(
    input  logic [NUM_CLUSTERS-1:0] req,
    input  logic [IDX_W-1:0]        ptr,
    output logic                    found,
    output logic [IDX_W-1:0]        idx
  );
    int unsigned cand;
    found = 1'b0;
    idx   = '0;
    for (int unsigned k = 0; k < NUM_CLUSTERS; k++) begin
      cand = int'(ptr) + k;
      if (cand >= NUM_CLUSTERS) begin
        cand = cand - NUM_CLUSTERS;
      end
      if (!found && req[cand]) begin
        found = 1'b1;
        idx   = IDX_W'(cand);
      end
    end
  endfunction

  function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
    if (idx == IDX_W'(NUM_CLUSTERS - 1)) begin
      return '0;
    end
    return idx + 1'b1;
  endfunction

  // Two independent arbiters, one for tasks and one for feedback
  always_comb begin
    for (int i = 0; i < NUM_CLUSTERS; i++) begin
      has_credit[i] = (credit_q[i] != '0);
    end
    rr_search(has_credit, rr_task_q, task_found, task_pick);
    rr_search(cluster_feedback_valid_i, rr_fb_q, fb_found, fb_pick);
  end

  assign task_ready_o   = !slot_valid_q && task_found;
  assign task_load      = task_valid_i && task_ready_o;
  assign slot_drain     = slot_valid_q && cluster_task_ready_i[slot_cl_q];
  assign cluster_task_o = slot_q;

  // Feedback register frees up in the same cycle the NIC takes it
  assign fb_free    = !fb_valid_q || fb_ready_i;
  assign fb_acc     = fb_free && fb_found;
  assign fb_valid_o = fb_valid_q;
  assign fb_o       = fb_q;

  for (genvar i = 0; i < NUM_CLUSTERS; i++) begin : gen_cluster_hs
    assign cluster_task_valid_o[i]     = slot_valid_q && (slot_cl_q == IDX_W'(i));
    assign cluster_feedback_ready_o[i] = fb_free && (!fb_found || fb_pick == IDX_W'(i));
  end

  always_comb begin
    fb_tagged            = cluster_feedback_i[fb_pick];
    fb_tagged.cluster_id = CL_ID_W'(fb_pick);
  end

  // Credit bookkeeping, a take and a return in one cycle cancel out
  always_comb begin
    credit_d = credit_q;
    active_d = 1'b0;
    for (int i = 0; i < NUM_CLUSTERS; i++) begin
      if (task_load && task_pick == IDX_W'(i)) begin
        credit_d[i] = credit_d[i] - 1'b1;
      end
      if (fb_acc && fb_pick == IDX_W'(i) && credit_d[i] < CR_W'(HERS_PER_CLUSTER)) begin
        credit_d[i] = credit_d[i] + 1'b1;
      end
      if (credit_d[i] < CR_W'(HERS_PER_CLUSTER)) begin
        active_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q     <= {NUM_CLUSTERS{CR_W'(HERS_PER_CLUSTER)}};
      slot_valid_q <= 1'b0;
      slot_cl_q    <= '0;
      rr_task_q    <= '0;
      fb_valid_q   <= 1'b0;
      rr_fb_q      <= '0;
      active_q     <= 1'b0;
    end else begin
      credit_q <= credit_d;
      active_q <= active_d;
      if (task_load) begin
        slot_valid_q <= 1'b1;
        slot_cl_q    <= task_pick;
        rr_task_q    <= next_idx(task_pick);
      end else if (slot_drain) begin
        slot_valid_q <= 1'b0;
      end
      if (fb_acc) begin
        fb_valid_q <= 1'b1;
        rr_fb_q    <= next_idx(fb_pick);
      end else if (fb_ready_i) begin
        fb_valid_q <= 1'b0;
      end
    end
  end

  // Task slot and feedback payloads
  always_ff @(posedge clk_i) begin
    if (task_load) begin
      slot_q <= task_i;
    end
    if (fb_acc) begin
      fb_q <= fb_tagged;
    end
  end

  assign pspin_active_o = active_q;

endmodule

`default_nettype wire

// ==== logic/task_fifo.sv ====
// Circular FIFO for any packed payload type
// The head is valid from the cycle after its write
// When full, a write is taken in the same cycle as a read of the head
`default_nettype none

module task_fifo #(
  parameter int unsigned DEPTH = 4,
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             push;
  logic             pop;

  // Pointer advance with wrap at DEPTH
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full        = (count_q == CNT_W'(DEPTH));
  assign in_ready_o  = !full || out_ready_i;
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/her_intake.sv ====
// HER intake with one occupancy counter per MPQ
// The NIC must hold her_i stable while her_valid_i is high
// MPQ ids at or above NUM_MPQ are forwarded but not counted
// Feedback reaches the NIC combinationally, without a register
`default_nettype none

module her_intake import pspin_sched_pkg::*; #(
  parameter int unsigned NUM_MPQ   = DEF_NUM_MPQ,
  parameter int unsigned MPQ_DEPTH = DEF_MPQ_DEPTH
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               her_valid_i,
  output logic               her_ready_o,
  input  her_descr_t         her_i,
  output logic [NUM_MPQ-1:0] mpq_full_o,
  output logic               task_valid_o,
  input  logic               task_ready_i,
  output her_descr_t         task_o,
  input  logic               fb_valid_i,
  output logic               fb_ready_o,
  input  feedback_descr_t    fb_i,
  output logic               nic_feedback_valid_o,
  input  logic               nic_feedback_ready_i,
  output feedback_descr_t    nic_feedback_o
);

  localparam int unsigned CNT_W = $clog2(MPQ_DEPTH + 1);

  logic [NUM_MPQ-1:0][CNT_W-1:0] cnt_q, cnt_d;
  logic [NUM_MPQ-1:0]            full_q, full_d;
  logic                          mpq_open;
  logic                          her_acc;
  logic                          nic_hs;

  // Room left in the MPQ named on the HER port
  always_comb begin
    mpq_open = 1'b1;
    for (int m = 0; m < NUM_MPQ; m++) begin
      if (her_i.mpq_id == MPQ_ID_W'(m) && cnt_q[m] >= CNT_W'(MPQ_DEPTH)) begin
        mpq_open = 1'b0;
      end
    end
  end

  assign task_valid_o = her_valid_i & mpq_open;
  assign task_o       = her_i;
  assign her_ready_o  = task_ready_i & mpq_open;
  assign her_acc      = her_valid_i & her_ready_o;

  // Dispatcher feedback goes straight out to the NIC
  assign nic_feedback_valid_o = fb_valid_i;
  assign nic_feedback_o       = fb_i;
  assign fb_ready_o           = nic_feedback_ready_i;
  assign nic_hs               = fb_valid_i & nic_feedback_ready_i;

  // Up on acceptance, down on the NIC handshake, both at once cancel out
  always_comb begin
    logic inc;
    logic dec;
    inc   = 1'b0;
    dec   = 1'b0;
    cnt_d = cnt_q;
    for (int m = 0; m < NUM_MPQ; m++) begin
      inc = her_acc && (her_i.mpq_id == MPQ_ID_W'(m));
      dec = nic_hs && (fb_i.mpq_id == MPQ_ID_W'(m)) && (cnt_q[m] != '0);
      if (inc && !dec) begin
        cnt_d[m] = cnt_q[m] + 1'b1;
      end else if (dec && !inc) begin
        cnt_d[m] = cnt_q[m] - 1'b1;
      end
      full_d[m] = (cnt_d[m] == CNT_W'(MPQ_DEPTH));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      full_q <= '0;
    end else begin
      cnt_q  <= cnt_d;
      full_q <= full_d;
    end
  end

  assign mpq_full_o = full_q;

endmodule

`default_nettype wire

// ==== logic/pspin_sched_pkg.sv ====
// Widths, descriptor formats and default sizes shared by the scheduler
// MPQ_ID_W limits the design to 256 MPQs
// CL_ID_W limits the design to 64 clusters
`default_nettype none

package pspin_sched_pkg;

  // Field widths
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned SIZE_W   = 16;
  localparam int unsigned MPQ_ID_W = 8;
  localparam int unsigned CL_ID_W  = 6;

  // Defaults for the top-level parameters
  localparam int unsigned DEF_NUM_CLUSTERS     = 4;
  localparam int unsigned DEF_NUM_MPQ          = 8;
  localparam int unsigned DEF_MPQ_DEPTH        = 4;
  localparam int unsigned DEF_HERS_PER_CLUSTER = 2;
  localparam int unsigned DEF_FIFO_DEPTH       = 4;

  // Handler execution request (88 bits)
  // Also carried unchanged as the task handed to a cluster
  typedef struct packed {
    logic [MPQ_ID_W-1:0] mpq_id;
    logic [ADDR_W-1:0]   handler_addr;
    logic [ADDR_W-1:0]   pkt_addr;
    logic [SIZE_W-1:0]   pkt_size;
  } her_descr_t;

  // Completion feedback (62 bits)
  typedef struct packed {
    logic [MPQ_ID_W-1:0] mpq_id;
    logic [CL_ID_W-1:0]  cluster_id;
    logic [ADDR_W-1:0]   pkt_addr;
    logic [SIZE_W-1:0]   pkt_size;
  } feedback_descr_t;

endpackage

`default_nettype wire
